// ==== capsense_clkgen_params.svh ====
//**************************************************************************
// CapSense scan clock generator constants
//**************************************************************************

`ifndef CAPSENSE_CLKGEN_PARAMS_SVH
`define CAPSENSE_CLKGEN_PARAMS_SVH

// Control register location and bus address width
`define CTRL_ADDR           'h0
`define AXIL_ADDR_W         4

// Bit positions inside the control register
`define CTRL_SYNC_BIT       0
`define CTRL_MEAS_BIT       1
`define CTRL_CH0_BIT        2
`define CTRL_CH1_BIT        3
`define CTRL_PRS_BIT        4

// Precharge prescaler reload and level threshold giving 50 % duty
`define PRESCALE_PERIOD     7
`define PRESCALE_COMPARE    3

// Scan-speed counter reload, so one dpulse every 32 enabled cycles
`define SCAN_SPEED_PERIOD   31

// Galois LFSR feedback mask and start value
`define PRS_POLY            8'hB8
`define PRS_SEED            8'hFF

// Shield polarity where 0 selects source and 1 selects sink
`define IDAC_SINK           0

`endif

// ==== capsense_clkgen_pkg.sv ====
//**************************************************************************
// CapSense clock generator types
//**************************************************************************

`default_nettype none

`include "capsense_clkgen_params.svh"

package capsense_clkgen_pkg;

    // Raw contents of the single control register
    typedef logic [7:0] ctrl_word_t;

    // AXI4-Lite address and data
    typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // Counter and shift register widths of the datapath
    typedef logic [7:0] presc_count_t;
    typedef logic [7:0] prs_state_t;
    typedef logic [4:0] scan_count_t;

    // Scan sequencer states in the order they are visited
    typedef enum logic [1:0]
    {
        SCAN_IDLE     = 2'd0,
        SCAN_HOLD     = 2'd1,
        SCAN_MEAS_RST = 2'd2,
        SCAN_WORK     = 2'd3
    } scan_state_e;

endpackage

`default_nettype wire

// ==== ctrl_reg_axil.sv ====
//**************************************************************************
// AXI4-Lite control register
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "capsense_clkgen_params.svh"

module ctrl_reg_axil
(
    input  wire                              op_clock,
    input  wire                              inter_reset,
    input  wire capsense_clkgen_pkg::axil_addr_t awaddr,
    input  wire                              awvalid,
    output logic                             awready,
    input  wire capsense_clkgen_pkg::axil_data_t wdata,
    input  wire [3:0]                        wstrb,
    input  wire                              wvalid,
    output logic                             wready,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  wire                              bready,
    input  wire capsense_clkgen_pkg::axil_addr_t araddr,
    input  wire                              arvalid,
    output logic                             arready,
    output capsense_clkgen_pkg::axil_data_t  rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  wire                              rready,
    output logic                             sync_en,
    output logic                             meas_en,
    output logic                             ch0_en,
    output logic                             ch1_en,
    output logic                             prs_sel
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    capsense_clkgen_pkg::ctrl_word_t ctrl_word;
    logic                            wr_accept;
    logic                            rd_accept;
    logic                            wr_hit;
    logic                            rd_hit;

    //**************************************************************************
    // Handshakes
    //**************************************************************************

    // Address and data are taken together and only with no response waiting
    assign wr_accept = awvalid & wvalid & ~bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    // One read in flight at a time
    assign arready   = ~rvalid;
    assign rd_accept = arvalid & arready;

    assign wr_hit = (awaddr == capsense_clkgen_pkg::axil_addr_t'(`CTRL_ADDR));
    assign rd_hit = (araddr == capsense_clkgen_pkg::axil_addr_t'(`CTRL_ADDR));

    // Valid flags and the register itself
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            ctrl_word <= '0;
        end
        else
        begin
            if (wr_accept)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (rd_accept)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
            // Only the low byte lane carries register bits
            if (wr_accept && wr_hit && wstrb[0])
                ctrl_word <= wdata[7:0];
        end
    end

    // Response payload is captured at accept and held until taken
    always_ff @(posedge op_clock)
    begin
        if (wr_accept)
            bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        if (rd_accept)
        begin
            rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
            rdata <= rd_hit ? {24'b0, ctrl_word} : '0;
        end
    end

    //**************************************************************************
    // Decoded enables
    //**************************************************************************

    assign sync_en = ctrl_word[`CTRL_SYNC_BIT];
    assign meas_en = ctrl_word[`CTRL_MEAS_BIT];
    assign ch0_en  = ctrl_word[`CTRL_CH0_BIT];
    assign ch1_en  = ctrl_word[`CTRL_CH1_BIT];
    assign prs_sel = ctrl_word[`CTRL_PRS_BIT];

endmodule

`default_nettype wire

// ==== scan_sequencer.sv ====
//**************************************************************************
// Scan sequencer FSM
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module scan_sequencer
(
    input  wire  op_clock,
    input  wire  inter_reset,
    input  wire  sync_en,
    input  wire  meas_en,
    output logic scan_hold,
    output logic mesrst,
    output logic work_en
);

    capsense_clkgen_pkg::scan_state_e state_q;
    capsense_clkgen_pkg::scan_state_e state_d;

    // Next state from the control bits
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            capsense_clkgen_pkg::SCAN_IDLE:
                if (sync_en)
                    state_d = capsense_clkgen_pkg::SCAN_HOLD;
            // Hold lasts exactly one cycle to restart the counters
            capsense_clkgen_pkg::SCAN_HOLD:
                state_d = capsense_clkgen_pkg::SCAN_MEAS_RST;
            capsense_clkgen_pkg::SCAN_MEAS_RST:
                if (meas_en)
                    state_d = capsense_clkgen_pkg::SCAN_WORK;
            capsense_clkgen_pkg::SCAN_WORK:
                if (!sync_en)
                    state_d = capsense_clkgen_pkg::SCAN_IDLE;
            default:
                state_d = capsense_clkgen_pkg::SCAN_IDLE;
        endcase
    end

    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
            state_q <= capsense_clkgen_pkg::SCAN_IDLE;
        else
            state_q <= state_d;
    end

    // Each output marks one state of the registered machine
    assign scan_hold = (state_q == capsense_clkgen_pkg::SCAN_HOLD);
    assign mesrst    = (state_q == capsense_clkgen_pkg::SCAN_MEAS_RST);
    assign work_en   = (state_q == capsense_clkgen_pkg::SCAN_WORK);

endmodule

`default_nettype wire

// ==== precharge_prescaler.sv ====
//**************************************************************************
// Precharge prescaler
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "capsense_clkgen_params.svh"

module precharge_prescaler
(
    input  wire  op_clock,
    input  wire  inter_reset,
    input  wire  enable,
    input  wire  scan_hold,
    output logic prech_level,
    output logic prech_edge
);

    localparam capsense_clkgen_pkg::presc_count_t RELOAD =
        capsense_clkgen_pkg::presc_count_t'(`PRESCALE_PERIOD);
    localparam capsense_clkgen_pkg::presc_count_t THRESHOLD =
        capsense_clkgen_pkg::presc_count_t'(`PRESCALE_COMPARE);

    capsense_clkgen_pkg::presc_count_t count;
    logic                              raw_level;
    logic                              level_dly;

    // Down-counter restarts during hold and wraps back to the reload value
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
            count <= RELOAD;
        else if (scan_hold)
            count <= RELOAD;
        else if (enable)
        begin
            if (count == '0)
                count <= RELOAD;
            else
                count <= count - 1'b1;
        end
    end

    // Lower part of the count gives the high half of the wave
    assign raw_level = (count <= THRESHOLD);

    // Registered wave plus a copy one cycle older for the edge detect
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            prech_level <= 1'b0;
            level_dly   <= 1'b0;
        end
        else
        begin
            prech_level <= raw_level;
            level_dly   <= prech_level;
        end
    end

    // Single-cycle strobe on each rising edge, used to pace the PRS
    assign prech_edge = prech_level & ~level_dly;

endmodule

`default_nettype wire

// ==== prs_generator.sv ====
//**************************************************************************
// 8-bit PRS generator
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "capsense_clkgen_params.svh"

module prs_generator
(
    input  wire  op_clock,
    input  wire  inter_reset,
    input  wire  enable,
    input  wire  scan_hold,
    input  wire  prech_edge,
    output logic prs_bit
);

    capsense_clkgen_pkg::prs_state_t lfsr;
    capsense_clkgen_pkg::prs_state_t lfsr_next;

    // Galois step with a zero shifted in and the mask applied on a set MSB
    assign lfsr_next = {lfsr[6:0], 1'b0} ^ (lfsr[7] ? `PRS_POLY : 8'h00);

    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
            lfsr <= `PRS_SEED;
        else if (scan_hold)
            lfsr <= `PRS_SEED;
        else if (enable && prech_edge)
            lfsr <= lfsr_next;
    end

    // Output bit trails the shift by one cycle
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
            prs_bit <= 1'b0;
        else
            prs_bit <= lfsr[7];
    end

endmodule

`default_nettype wire

// ==== pulse_output_stage.sv ====
//**************************************************************************
// Scan pulse output stage
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "capsense_clkgen_params.svh"

module pulse_output_stage
(
    input  wire  op_clock,
    input  wire  inter_reset,
    input  wire  enable,
    input  wire  scan_hold,
    input  wire  work_en,
    input  wire  ch0_en,
    input  wire  ch1_en,
    input  wire  prs_sel,
    input  wire  prech_level,
    input  wire  prs_bit,
    output logic dpulse,
    output logic ppulse,
    output logic shield,
    output logic start0,
    output logic start1
);

    localparam capsense_clkgen_pkg::scan_count_t SCAN_RELOAD =
        capsense_clkgen_pkg::scan_count_t'(`SCAN_SPEED_PERIOD);

    capsense_clkgen_pkg::scan_count_t scan_count;

    //**************************************************************************
    // Scan-speed counter
    //**************************************************************************

    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
            scan_count <= SCAN_RELOAD;
        else if (scan_hold)
            scan_count <= SCAN_RELOAD;
        else if (enable)
        begin
            if (scan_count == '0)
                scan_count <= SCAN_RELOAD;
            else
                scan_count <= scan_count - 1'b1;
        end
    end

    // Terminal count is the digital scan clock
    assign dpulse = (scan_count == '0);

    //**************************************************************************
    // Precharge source and channel starts
    //**************************************************************************

    // Spread-spectrum stream or plain square wave
    assign ppulse = prs_sel ? prs_bit : prech_level;

    // Sink mode drives the shield in opposite phase
    assign shield = (`IDAC_SINK != 0) ? ~ppulse : ppulse;

    assign start0 = work_en & ch0_en;
    assign start1 = work_en & ch1_en;

endmodule

`default_nettype wire

// ==== capsense_clkgen_top.sv ====
//**************************************************************************
// CapSense scan clock generator top
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module capsense_clkgen_top
(
    input  wire                              op_clock,
    input  wire                              inter_reset,
    input  wire                              enable,
    input  wire capsense_clkgen_pkg::axil_addr_t awaddr,
    input  wire                              awvalid,
    output logic                             awready,
    input  wire capsense_clkgen_pkg::axil_data_t wdata,
    input  wire [3:0]                        wstrb,
    input  wire                              wvalid,
    output logic                             wready,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  wire                              bready,
    input  wire capsense_clkgen_pkg::axil_addr_t araddr,
    input  wire                              arvalid,
    output logic                             arready,
    output capsense_clkgen_pkg::axil_data_t  rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  wire                              rready,
    output logic                             dpulse,
    output logic                             ppulse,
    output logic                             shield,
    output logic                             start0,
    output logic                             start1,
    output logic                             mesrst
);

    // Decoded control bits
    logic sync_en;
    logic meas_en;
    logic ch0_en;
    logic ch1_en;
    logic prs_sel;

    // Sequencer phases and precharge timing
    logic scan_hold;
    logic work_en;
    logic prech_level;
    logic prech_edge;
    logic prs_bit;

    // Bus-side register
    ctrl_reg_axil u_ctrl
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .sync_en     (sync_en),
        .meas_en     (meas_en),
        .ch0_en      (ch0_en),
        .ch1_en      (ch1_en),
        .prs_sel     (prs_sel)
    );

    scan_sequencer u_seq
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .sync_en     (sync_en),
        .meas_en     (meas_en),
        .scan_hold   (scan_hold),
        .mesrst      (mesrst),
        .work_en     (work_en)
    );

    precharge_prescaler u_presc
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .enable      (enable),
        .scan_hold   (scan_hold),
        .prech_level (prech_level),
        .prech_edge  (prech_edge)
    );

    prs_generator u_prs
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .enable      (enable),
        .scan_hold   (scan_hold),
        .prech_edge  (prech_edge),
        .prs_bit     (prs_bit)
    );

    // Output pins come from the last stage
    pulse_output_stage u_out
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .enable      (enable),
        .scan_hold   (scan_hold),
        .work_en     (work_en),
        .ch0_en      (ch0_en),
        .ch1_en      (ch1_en),
        .prs_sel     (prs_sel),
        .prech_level (prech_level),
        .prs_bit     (prs_bit),
        .dpulse      (dpulse),
        .ppulse      (ppulse),
        .shield      (shield),
        .start0      (start0),
        .start1      (start1)
    );

endmodule

`default_nettype wire

// ==== tb_capsense_clkgen.sv ====
//**************************************************************************
// CapSense clock generator testbench
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "capsense_clkgen_params.svh"

module tb_capsense_clkgen;

    localparam int TIMEOUT = 400;
    localparam int ROW_W   = `AXIL_ADDR_W + 32 + 2 + 4;
    localparam int ROWS    = 10;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;
    localparam capsense_clkgen_pkg::axil_addr_t CTRL =
        capsense_clkgen_pkg::axil_addr_t'(`CTRL_ADDR);

    logic op_clock;
    logic inter_reset;
    logic enable;
    capsense_clkgen_pkg::axil_addr_t awaddr;
    logic awvalid;
    logic awready;
    capsense_clkgen_pkg::axil_data_t wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    capsense_clkgen_pkg::axil_addr_t araddr;
    logic arvalid;
    logic arready;
    capsense_clkgen_pkg::axil_data_t rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic dpulse;
    logic ppulse;
    logic shield;
    logic start0;
    logic start1;
    logic mesrst;

    // Row fields are address, write data, response, start0, start1, prs_sel, enable
    logic [ROW_W-1:0] table_rows [0:ROWS-1];
    int errors;
    int checks;
    int seed;
    capsense_clkgen_pkg::ctrl_word_t shadow;

    capsense_clkgen_top dut0
    (
        .op_clock (op_clock), .inter_reset (inter_reset), .enable (enable),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .dpulse (dpulse), .ppulse (ppulse), .shield (shield),
        .start0 (start0), .start1 (start1), .mesrst (mesrst)
    );

    initial
    begin
        op_clock = 1'b0;
        forever #5 op_clock = ~op_clock;
    end

    //**************************************************************************
    // Checking helpers
    //**************************************************************************

    task automatic check_value(input string what, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // A stuck handshake ends the run at once
    task automatic stop_on_timeout(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        $display("Checks run: %0d, errors: %0d", checks, errors + 1);
        $display("Checks failed");
        $finish;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge op_clock);
    endtask

    //**************************************************************************
    // AXI4-Lite driver
    //**************************************************************************

    task automatic axil_write(input capsense_clkgen_pkg::axil_addr_t addr,
                              input capsense_clkgen_pkg::axil_data_t data,
                              output logic [1:0] resp);
        int n;
        int dly;
        @(posedge op_clock);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hF;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        n = 0;
        @(negedge op_clock);
        while (!(awready && wready))
        begin
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("awready and wready");
            @(negedge op_clock);
        end
        @(posedge op_clock);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        // Random back-pressure on the write response
        dly = int'($unsigned($random(seed)) % 4);
        repeat (dly) @(posedge op_clock);
        bready <= 1'b1;
        n = 0;
        @(negedge op_clock);
        while (!bvalid)
        begin
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("bvalid");
            @(negedge op_clock);
        end
        resp = bresp;
        @(posedge op_clock);
        bready <= 1'b0;
    endtask

    task automatic axil_read(input capsense_clkgen_pkg::axil_addr_t addr,
                             output capsense_clkgen_pkg::axil_data_t data,
                             output logic [1:0] resp);
        int n;
        int dly;
        @(posedge op_clock);
        araddr  <= addr;
        arvalid <= 1'b1;
        n = 0;
        @(negedge op_clock);
        while (!arready)
        begin
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("arready");
            @(negedge op_clock);
        end
        @(posedge op_clock);
        arvalid <= 1'b0;
        dly = int'($unsigned($random(seed)) % 4);
        repeat (dly) @(posedge op_clock);
        rready <= 1'b1;
        n = 0;
        @(negedge op_clock);
        while (!rvalid)
        begin
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("rvalid");
            @(negedge op_clock);
        end
        data = rdata;
        resp = rresp;
        @(posedge op_clock);
        rready <= 1'b0;
    endtask

    task automatic wait_mesrst(input logic level);
        int n;
        n = 0;
        @(negedge op_clock);
        while (mesrst !== level)
        begin
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("mesrst");
            @(negedge op_clock);
        end
    endtask

    //**************************************************************************
    // Output behavior checks
    //**************************************************************************

    // Interval between two dpulse rising edges
    task automatic check_dpulse_period();
        int n;
        int gap;
        logic prev;
        logic found;
        @(negedge op_clock);
        prev  = dpulse;
        found = 1'b0;
        n = 0;
        while (!found)
        begin
            @(negedge op_clock);
            found = dpulse & ~prev;
            prev  = dpulse;
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("a dpulse edge");
        end
        gap   = 0;
        found = 1'b0;
        while (!found)
        begin
            @(negedge op_clock);
            gap++;
            found = dpulse & ~prev;
            prev  = dpulse;
            if (gap > TIMEOUT)
                stop_on_timeout("the next dpulse edge");
        end
        check_value("dpulse period", gap, `SCAN_SPEED_PERIOD + 1);
    endtask

    // Period and high time of the square wave, with the shield polarity
    task automatic check_precharge_wave();
        int n;
        int per;
        int hi;
        logic prev;
        logic found;
        logic lvl;
        @(negedge op_clock);
        prev  = ppulse;
        found = 1'b0;
        n = 0;
        while (!found)
        begin
            @(negedge op_clock);
            found = ppulse & ~prev;
            prev  = ppulse;
            n++;
            if (n > TIMEOUT)
                stop_on_timeout("a ppulse edge");
        end
        per   = 0;
        hi    = 1;
        found = 1'b0;
        while (!found)
        begin
            @(negedge op_clock);
            per++;
            // Expected wave is high for the first COMPARE+1 cycles of each period
            lvl = ((per % (`PRESCALE_PERIOD + 1)) <= `PRESCALE_COMPARE);
            check_value("shield", 32'(shield), 32'((`IDAC_SINK == 1) ? !lvl : lvl));
            found = ppulse & ~prev;
            if (ppulse && !found)
                hi++;
            prev = ppulse;
            if (per > TIMEOUT)
                stop_on_timeout("the next ppulse edge");
        end
        check_value("ppulse period", per, `PRESCALE_PERIOD + 1);
        check_value("ppulse high time", hi, `PRESCALE_COMPARE + 1);
    endtask

    task automatic check_dpulse_quiet();
        int rises;
        logic prev;
        rises = 0;
        @(negedge op_clock);
        prev = dpulse;
        repeat (200)
        begin
            @(negedge op_clock);
            if (dpulse && !prev)
                rises++;
            prev = dpulse;
        end
        check_value("dpulse edges with enable low", rises, 0);
    endtask

    function automatic capsense_clkgen_pkg::prs_state_t lfsr_step(
        input capsense_clkgen_pkg::prs_state_t s);
        capsense_clkgen_pkg::prs_state_t t;
        t = {s[6:0], 1'b0};
        if (s[7])
            t = t ^ `PRS_POLY;
        return t;
    endfunction

    // Counters sit frozen at their reload values, so releasing enable fixes the phase
    task automatic check_prs_stream();
        capsense_clkgen_pkg::prs_state_t model;
        model = `PRS_SEED;
        @(posedge op_clock);
        enable <= 1'b1;
        repeat (`PRESCALE_PERIOD - `PRESCALE_COMPARE + 3) @(posedge op_clock);
        for (int k = 0; k < 32; k++)
        begin
            if (k > 0)
                repeat (`PRESCALE_PERIOD + 1) @(posedge op_clock);
            @(negedge op_clock);
            model = lfsr_step(model);
            check_value("prs bit", 32'(ppulse), 32'(model[7]));
        end
    endtask

    //**************************************************************************
    // Stimulus table and main sequence
    //**************************************************************************

    initial
    begin
        capsense_clkgen_pkg::axil_addr_t addr;
        capsense_clkgen_pkg::axil_data_t data;
        capsense_clkgen_pkg::axil_data_t rd;
        logic [1:0] exp_resp;
        logic [1:0] resp;
        logic exp_s0;
        logic exp_s1;
        logic row_prs;
        logic row_en;
        errors = 0;
        checks = 0;
        seed   = 87767;
        shadow = '0;
        inter_reset = 1'b1;
        enable  = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'h0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        table_rows[0] = {CTRL, 32'h0000_0001, OKAY, 1'b0, 1'b0, 1'b0, 1'b1};
        table_rows[1] = {4'h4, 32'h0000_00FF, SLVERR, 1'b0, 1'b0, 1'b0, 1'b1};
        table_rows[2] = {CTRL, 32'hDEAD_0007, OKAY, 1'b1, 1'b0, 1'b0, 1'b1};
        table_rows[3] = {CTRL, 32'h0000_0000, OKAY, 1'b0, 1'b0, 1'b0, 1'b1};
        table_rows[4] = {4'h8, 32'h0000_001B, SLVERR, 1'b0, 1'b0, 1'b0, 1'b1};
        table_rows[5] = {CTRL, 32'h1234_560B, OKAY, 1'b0, 1'b1, 1'b0, 1'b1};
        table_rows[6] = {CTRL, 32'h0000_0000, OKAY, 1'b0, 1'b0, 1'b0, 1'b1};
        table_rows[7] = {CTRL, 32'h0000_0011, OKAY, 1'b0, 1'b0, 1'b1, 1'b0};
        table_rows[8] = {CTRL, 32'h0000_001F, OKAY, 1'b1, 1'b1, 1'b1, 1'b1};
        table_rows[9] = {CTRL, 32'h0000_0000, OKAY, 1'b0, 1'b0, 1'b0, 1'b1};
        repeat (8) @(posedge op_clock);
        inter_reset <= 1'b0;
        @(negedge op_clock);
        check_value("mesrst after reset", 32'(mesrst), 0);
        check_value("start0 after reset", 32'(start0), 0);
        check_value("start1 after reset", 32'(start1), 0);
        for (int i = 0; i < ROWS; i++)
        begin
            {addr, data, exp_resp, exp_s0, exp_s1, row_prs, row_en} = table_rows[i];
            // The PRS row keeps enable low until the sequencer reaches work
            if (!(row_prs && row_en))
            begin
                @(posedge op_clock);
                enable <= row_en;
            end
            axil_write(addr, data, resp);
            check_value("write response", 32'(resp), 32'(exp_resp));
            if (exp_resp == OKAY)
                shadow = data[7:0];
            wait_cycles(4);
            if (shadow[`CTRL_SYNC_BIT] && !shadow[`CTRL_MEAS_BIT])
                wait_mesrst(1'b1);
            else if (shadow[`CTRL_SYNC_BIT])
            begin
                @(negedge op_clock);
                check_value("mesrst in work", 32'(mesrst), 0);
            end
            @(negedge op_clock);
            check_value("start0", 32'(start0), 32'(exp_s0));
            check_value("start1", 32'(start1), 32'(exp_s1));
            if (!row_en)
                check_dpulse_quiet();
            else if (row_prs)
                check_prs_stream();
            else if (shadow[`CTRL_SYNC_BIT] && shadow[`CTRL_MEAS_BIT])
            begin
                check_dpulse_period();
                check_precharge_wave();
            end
            axil_read(addr, rd, resp);
            check_value("read response", 32'(resp), 32'(exp_resp));
            if (exp_resp == OKAY)
                check_value("read-back", int'(rd), 32'(shadow));
            else
            begin
                check_value("error read data", int'(rd), 0);
                axil_read(CTRL, rd, resp);
                check_value("register after bad access", int'(rd), 32'(shadow));
            end
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
capsense_clkgen_pkg.sv
ctrl_reg_axil.sv
scan_sequencer.sv
precharge_prescaler.sv
prs_generator.sv
pulse_output_stage.sv
capsense_clkgen_top.sv
tb_capsense_clkgen.sv

// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing -f flist.f --top-module tb_capsense_clkgen -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

lint:
	verilator --lint-only --timing -f flist.f --top-module capsense_clkgen_top

clean:
	rm -rf obj_dir
